// File: design/cdb_arbiter.sv
// round-robin completion grant and the registered common data bus
module cdb_arbiter
    import core_types_pkg::*;
    import core_config_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [NUM_UNITS-1:0] done,
    input  tag_t                 result_tag   [NUM_UNITS],
    input  data_t                result_value [NUM_UNITS],
    input  logic                 cdb_ready,
    output logic [NUM_UNITS-1:0] grant,
    output logic                 cdb_valid,
    output tag_t                 cdb_tag,
    output data_t                cdb_value
);

    logic [UNIT_IDX_W-1:0] rr_ptr;    // first unit to look at
    logic [UNIT_IDX_W-1:0] gnt_idx;
    logic                  any_grant;

    //////////////////////////////
    // grant select
    //////////////////////////////

    // first finished unit at or after the pointer while ready is high
    always_comb begin
        logic [UNIT_IDX_W-1:0] idx;
        logic                  found;
        grant   = '0;
        gnt_idx = '0;
        found   = 1'b0;
        for (int off = 0; off < NUM_UNITS; off++) begin
            idx = UNIT_IDX_W'((int'(rr_ptr) + off) % NUM_UNITS);
            if (cdb_ready && done[idx] && !found) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                gnt_idx    = idx;
            end
        end
    end

    assign any_grant = |grant;

    //////////////////////////////
    // bus register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
            rr_ptr    <= '0;
        end else begin
            cdb_valid <= any_grant;
            if (any_grant) begin
                // move past the winner
                if (gnt_idx == UNIT_IDX_W'(NUM_UNITS - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= gnt_idx + UNIT_IDX_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (any_grant) begin
            cdb_tag   <= result_tag[gnt_idx];
            cdb_value <= result_value[gnt_idx];
        end
    end

endmodule

// File: design/core_config_pkg.sv
// sizes of the execute block: unit count, queue depth, multiply latency, derived widths
package core_config_pkg;

    localparam int NUM_UNITS   = 4;   // identical execution units
    localparam int QUEUE_DEPTH = 8;   // dispatch queue entries
    localparam int MUL_LATENCY = 3;   // issue edge to done for multiply, 2 or more

    // derived widths
    localparam int UNIT_IDX_W  = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;
    localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int MUL_CNT_W   = $clog2(MUL_LATENCY + 1);

endpackage

// File: design/core_types_pkg.sv
// operand, tag and shift typedefs plus the operation code enum
package core_types_pkg;

    localparam int DATA_W  = 32;
    localparam int TAG_W   = 4;    // 16 operations in flight
    localparam int SHIFT_W = 5;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [SHIFT_W-1:0] shift_amt_t;   // low bits of operand b

    // operation codes carried with each entry
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_MUL = 3'd6
    } alu_op_e;

endpackage

// File: design/dispatch_queue.sv
// operation FIFO with issue to the lowest-numbered idle execution unit
module dispatch_queue
    import core_types_pkg::*;
    import core_config_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    input  alu_op_e              in_op,
    input  data_t                in_a,
    input  data_t                in_b,
    input  tag_t                 in_tag,
    input  logic [NUM_UNITS-1:0] unit_idle,
    output logic                 in_ready,
    output logic [NUM_UNITS-1:0] issue_valid,
    output alu_op_e              issue_op,
    output data_t                issue_a,
    output data_t                issue_b,
    output tag_t                 issue_tag
);

    // entry storage
    alu_op_e op_mem  [QUEUE_DEPTH];
    data_t   a_mem   [QUEUE_DEPTH];
    data_t   b_mem   [QUEUE_DEPTH];
    tag_t    tag_mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] head;
    logic [QUEUE_PTR_W-1:0] tail;
    logic [QUEUE_CNT_W-1:0] count;

    logic                 head_valid;
    logic                 push;
    logic                 pop;
    logic [NUM_UNITS-1:0] pick;

    assign head_valid = (count != '0);
    assign in_ready   = (count != QUEUE_CNT_W'(QUEUE_DEPTH));
    assign push       = in_valid & in_ready;
    assign pop        = |issue_valid;

    //////////////////////////////
    // issue select
    //////////////////////////////

    // walk downwards so the lowest idle unit wins
    always_comb begin
        pick = '0;
        for (int i = NUM_UNITS - 1; i >= 0; i--) begin
            if (unit_idle[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    assign issue_valid = head_valid ? pick : '0;
    assign issue_op    = op_mem[head];
    assign issue_a     = a_mem[head];
    assign issue_b     = b_mem[head];
    assign issue_tag   = tag_mem[head];

    //////////////////////////////
    // pointers and storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (push) begin
            op_mem[tail]  <= in_op;
            a_mem[tail]   <= in_a;
            b_mem[tail]   <= in_b;
            tag_mem[tail] <= in_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : tail + QUEUE_PTR_W'(1);
            end
            if (pop) begin
                head <= (head == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : head + QUEUE_PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + QUEUE_CNT_W'(1);
                2'b01:   count <= count - QUEUE_CNT_W'(1);
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

// File: design/exec_core.sv
// top of the execute block: dispatch queue, execution units and completion arbiter
module exec_core
    import core_types_pkg::*;
    import core_config_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    input  alu_op_e in_op,
    input  data_t   in_a,
    input  data_t   in_b,
    input  tag_t    in_tag,
    output logic    in_ready,
    input  logic    cdb_ready,
    output logic    cdb_valid,
    output tag_t    cdb_tag,
    output data_t   cdb_value
);

    // queue to units
    logic [NUM_UNITS-1:0] issue_valid;
    alu_op_e              issue_op;
    data_t                issue_a;
    data_t                issue_b;
    tag_t                 issue_tag;
    logic [NUM_UNITS-1:0] unit_idle;

    // units to arbiter
    logic [NUM_UNITS-1:0] unit_done;
    logic [NUM_UNITS-1:0] unit_grant;
    tag_t                 unit_result_tag   [NUM_UNITS];
    data_t                unit_result_value [NUM_UNITS];

    dispatch_queue queue_inst (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_a        (in_a),
        .in_b        (in_b),
        .in_tag      (in_tag),
        .unit_idle   (unit_idle),
        .in_ready    (in_ready),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_tag   (issue_tag)
    );

    //////////////////////////////
    // execution units
    //////////////////////////////

    for (genvar i = 0; i < NUM_UNITS; i++) begin : gen_unit
        exec_unit unit_inst (
            .clock        (clock),
            .reset        (reset),
            .issue_valid  (issue_valid[i]),
            .issue_op     (issue_op),      // shared issue payload
            .issue_a      (issue_a),
            .issue_b      (issue_b),
            .issue_tag    (issue_tag),
            .grant        (unit_grant[i]),
            .unit_idle    (unit_idle[i]),
            .done         (unit_done[i]),
            .result_tag   (unit_result_tag[i]),
            .result_value (unit_result_value[i])
        );
    end

    cdb_arbiter arbiter_inst (
        .clock        (clock),
        .reset        (reset),
        .done         (unit_done),
        .result_tag   (unit_result_tag),
        .result_value (unit_result_value),
        .cdb_ready    (cdb_ready),
        .grant        (unit_grant),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value)
    );

endmodule

// File: design/exec_unit.sv
// single execution unit: state machine, result compute and hold until granted
module exec_unit
    import core_types_pkg::*;
    import core_config_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    issue_valid,
    input  alu_op_e issue_op,
    input  data_t   issue_a,
    input  data_t   issue_b,
    input  tag_t    issue_tag,
    input  logic    grant,
    output logic    unit_idle,
    output logic    done,
    output tag_t    result_tag,
    output data_t   result_value
);

    typedef enum logic [1:0] {
        UNIT_IDLE,
        UNIT_MUL_WAIT,
        UNIT_DONE
    } unit_state_e;

    unit_state_e          state;
    logic [MUL_CNT_W-1:0] mul_cnt;   // cycles left before done
    shift_amt_t           shamt;
    data_t                alu_result;

    assign shamt = issue_b[SHIFT_W-1:0];

    //////////////////////////////
    // compute
    //////////////////////////////

    // all results wrap at 32 bits
    always_comb begin
        case (issue_op)
            OP_ADD:  alu_result = issue_a + issue_b;
            OP_SUB:  alu_result = issue_a - issue_b;
            OP_AND:  alu_result = issue_a & issue_b;
            OP_OR:   alu_result = issue_a | issue_b;
            OP_XOR:  alu_result = issue_a ^ issue_b;
            OP_SLL:  alu_result = issue_a << shamt;
            OP_MUL:  alu_result = issue_a * issue_b;   // low half of product
            default: alu_result = '0;
        endcase
    end

    // result captured on the issue edge and held until grant
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            result_tag   <= issue_tag;
            result_value <= alu_result;
        end
    end

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= UNIT_IDLE;
            mul_cnt <= '0;
        end else begin
            case (state)
                UNIT_IDLE: begin
                    if (issue_valid) begin
                        if (issue_op == OP_MUL) begin
                            state   <= UNIT_MUL_WAIT;
                            mul_cnt <= MUL_CNT_W'(MUL_LATENCY - 1);
                        end else begin
                            state <= UNIT_DONE;   // simple ops finish in one
                        end
                    end
                end
                UNIT_MUL_WAIT: begin
                    if (mul_cnt == MUL_CNT_W'(1)) begin
                        state <= UNIT_DONE;
                    end else begin
                        mul_cnt <= mul_cnt - MUL_CNT_W'(1);
                    end
                end
                UNIT_DONE: begin
                    if (grant) begin
                        state <= UNIT_IDLE;
                    end
                end
                default: state <= UNIT_IDLE;
            endcase
        end
    end

    assign unit_idle = (state == UNIT_IDLE);
    assign done      = (state == UNIT_DONE);

endmodule

// File: exec_core.f
design/core_config_pkg.sv
design/core_types_pkg.sv
design/dispatch_queue.sv
design/exec_unit.sv
design/cdb_arbiter.sv
design/exec_core.sv
tests/tb_clock_gen.sv
tests/exec_core_checker.sv
tests/exec_core_monitor.sv
tests/exec_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module exec_core_tb \
    -f exec_core.f \
    --Mdir obj_dir \
    -o sim_exec_core
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/sim_exec_core 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi

echo "pass message not found"
exit 1

// File: tests/exec_core_checker.sv
// concurrent assertions on the completion bus, input ready and grant, plus the bind
module exec_core_checker
    import core_config_pkg::*;
    import core_types_pkg::*;
(
    input logic                 clock,
    input logic                 reset,
    input logic                 in_ready,
    input logic                 cdb_ready,
    input logic                 cdb_valid,
    input tag_t                 cdb_tag,
    input data_t                cdb_value,
    input logic [NUM_UNITS-1:0] unit_grant
);
    timeunit 1ns;
    timeprecision 100ps;

    // no grant while ready is low, so the bus is empty a cycle later
    assert property (@(posedge clock) disable iff (reset) !cdb_ready |=> !cdb_valid)
        else $error("cdb_valid high in the cycle after cdb_ready was low");

    assert property (@(posedge clock) $fell(reset) |-> in_ready)
        else $error("in_ready low on the first cycle after reset");

    assert property (@(posedge clock) disable iff (reset)
                     cdb_valid |-> !$isunknown({cdb_tag, cdb_value}))
        else $error("unknown tag or value on the completion bus");

    assert property (@(posedge clock) disable iff (reset) $onehot0(unit_grant))
        else $error("more than one unit granted");

endmodule

bind exec_core exec_core_checker checker_inst (
    .clock      (clock),
    .reset      (reset),
    .in_ready   (in_ready),
    .cdb_ready  (cdb_ready),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .cdb_value  (cdb_value),
    .unit_grant (unit_grant)
);

// File: tests/exec_core_monitor.sv
// scoreboard: expected value per tag on acceptance, compared on each completion
module exec_core_monitor
    import core_types_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    input  logic    in_ready,
    input  alu_op_e in_op,
    input  data_t   in_a,
    input  data_t   in_b,
    input  tag_t    in_tag,
    input  logic    cdb_ready,
    input  logic    cdb_valid,
    input  tag_t    cdb_tag,
    input  data_t   cdb_value,
    output int      error_count,
    output int      accept_count,
    output int      complete_count,
    output int      pending_count
);
    timeunit 1ns;
    timeprecision 100ps;

    data_t expected [16];
    logic  in_flight [16];
    logic  prev_ready;

    // reference rules for each operation, 32-bit wrap
    function automatic data_t compute_expected(alu_op_e op, data_t a, data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_MUL:  return data_t'(64'(a) * 64'(b));   // low word of the product
            default: return 'x;
        endcase
    endfunction

    initial begin
        error_count = 0;
        accept_count = 0;
        complete_count = 0;
        pending_count = 0;
        prev_ready = 1'b1;
        for (int i = 0; i < 16; i++) in_flight[i] = 1'b0;
    end

    // inputs change 1 ns after the edge, so the negedge sees settled values
    always @(negedge clock) begin
        if (!reset) begin
            if (cdb_valid && !prev_ready) begin
                $display("error at %0t ns: completion right after cdb_ready was low", $time);
                error_count++;
            end
            if (cdb_valid) begin
                if (!in_flight[cdb_tag]) begin
                    $display("error at %0t ns: completion for tag %0d, which is not in flight",
                             $time, cdb_tag);
                    error_count++;
                end else begin
                    if (cdb_value !== expected[cdb_tag]) begin
                        $display("Fail at %0t ns: tag %0d value %h, expected %h",
                                 $time, cdb_tag, cdb_value, expected[cdb_tag]);
                        error_count++;
                    end
                    in_flight[cdb_tag] = 1'b0;
                    pending_count--;
                end
                complete_count++;
            end
            // acceptance happens on the coming edge
            if (in_valid && in_ready) begin
                if (in_flight[in_tag]) begin
                    $display("error at %0t ns: tag %0d sent again while in flight",
                             $time, in_tag);
                    error_count++;
                end
                expected[in_tag] = compute_expected(in_op, in_a, in_b);
                in_flight[in_tag] = 1'b1;
                accept_count++;
                pending_count++;
            end
            prev_ready = cdb_ready;
        end
    end

endmodule

// File: tests/exec_core_tb.sv
// testbench top with stimulus table, LFSR, drive loop, ready control, watchdog and counts
module exec_core_tb
    import core_types_pkg::*;
    import core_config_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        int      test;
        alu_op_e op;
        data_t   a;
        data_t   b;
        tag_t    tag;
    } row_t;

    logic    clock;
    logic    reset;
    logic    in_valid;
    logic    in_ready;
    logic    cdb_ready;
    logic    cdb_valid;
    alu_op_e in_op;
    data_t   in_a;
    data_t   in_b;
    data_t   cdb_value;
    tag_t    in_tag;
    tag_t    cdb_tag;
    int      error_count;
    int      accept_count;
    int      complete_count;
    int      pending_count;

    row_t rows[$];
    logic [31:0] lfsr = 32'h53e1;
    int ready_mode = 0;   // 0 high, 1 random, 2 low
    int tb_errors = 0;
    int tests_failed = 0;
    bit table_ready = 0;

    tb_clock_gen clock_gen_inst (.clock(clock), .reset(reset));

    exec_core exec_core_inst (
        .clock(clock), .reset(reset), .in_valid(in_valid), .in_op(in_op), .in_a(in_a),
        .in_b(in_b), .in_tag(in_tag), .in_ready(in_ready), .cdb_ready(cdb_ready),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

    exec_core_monitor monitor_inst (
        .clock(clock), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
        .in_op(in_op), .in_a(in_a), .in_b(in_b), .in_tag(in_tag), .cdb_ready(cdb_ready),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .error_count(error_count), .accept_count(accept_count),
        .complete_count(complete_count), .pending_count(pending_count)
    );

    // galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic add_row(int test, alu_op_e op, data_t a, data_t b, int tag);
        rows.push_back('{test, op, a, b, tag_t'(tag)});
    endtask

    task automatic build_table();
        logic [2:0] r;
        add_row(1, OP_ADD, 32'hffff_ffff, 32'h1, 0);        // wraps to zero
        add_row(1, OP_SUB, 32'h0, 32'h1, 1);
        add_row(1, OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 2);
        add_row(1, OP_OR,  32'hf000_0001, 32'h0000_8010, 3);
        add_row(1, OP_XOR, 32'haaaa_5555, 32'hffff_0000, 4);
        add_row(1, OP_SLL, 32'h8000_0001, 32'h0, 5);
        add_row(1, OP_SLL, 32'h0000_0003, 32'd31, 6);
        add_row(1, OP_SLL, 32'h0000_0001, 32'h25, 7);       // only low 5 bits count
        add_row(2, OP_MUL, 32'd7, 32'd6, 0);
        add_row(2, OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 1);
        add_row(2, OP_MUL, 32'h1234_5678, 32'h9abc_def0, 2);
        add_row(2, OP_MUL, 32'h8000_0000, 32'd2, 3);
        add_row(2, OP_MUL, 32'h0001_0000, 32'h0001_0000, 4);
        // mul then simple so the simple ones overtake
        for (int i = 0; i < 10; i++) begin
            add_row(3, (i % 2 == 0) ? OP_MUL : alu_op_e'(i % 6), take_bits(32),
                    take_bits(32), i);
        end
        for (int i = 0; i < 16; i++) begin
            r = 3'(take_bits(3));
            add_row(4, (r == 3'd7) ? OP_MUL : alu_op_e'(r), take_bits(32), take_bits(32), i);
        end
        for (int i = 0; i <= NUM_UNITS + QUEUE_DEPTH; i++) begin
            add_row(5, alu_op_e'(i % 7), take_bits(32), take_bits(32), i);
        end
    endtask

    // caller sits 1 ns after an edge
    task automatic send_row(row_t r, int max_wait, output bit accepted);
        int waited;
        waited = 0;
        in_valid = 1'b1;
        in_op = r.op;
        in_a = r.a;
        in_b = r.b;
        in_tag = r.tag;
        while (!in_ready && waited < max_wait) begin
            @(posedge clock);
            #1;
            waited++;
        end
        accepted = in_ready;
        if (accepted) begin
            @(posedge clock);
            #1;
        end
        in_valid = 1'b0;
    endtask

    always @(posedge clock) begin
        #1;
        case (ready_mode)
            1:       cdb_ready = 1'(take_bits(1));
            2:       cdb_ready = 1'b0;
            default: cdb_ready = 1'b1;
        endcase
    end

    ////////////////////////////////
    // watchdog
    ////////////////////////////////

    initial begin
        wait (table_ready);
        repeat (rows.size() * (MUL_LATENCY + QUEUE_DEPTH + 10)) @(posedge clock);
        $display("timeout: the run did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////
    // test sequence
    ////////////////////////////////

    initial begin
        int errs_before;
        int acc_before;
        int cmp_before;
        int sent;
        bit ok;
        in_valid = 1'b0;
        in_op = OP_ADD;
        in_a = '0;
        in_b = '0;
        in_tag = '0;
        cdb_ready = 1'b1;
        build_table();
        table_ready = 1;
        @(negedge reset);
        @(negedge clock);
        if (cdb_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("Fail at %0t ns: after reset cdb_valid %b in_ready %b",
                     $time, cdb_valid, in_ready);
            tb_errors++;
            tests_failed++;
        end
        $display("test 6 reset state: %s", (tb_errors == 0) ? "passed" : "failed");
        @(posedge clock);
        #1;
        for (int t = 1; t <= 5; t++) begin
            errs_before = error_count + tb_errors;
            acc_before = accept_count;
            cmp_before = complete_count;
            sent = 0;
            ready_mode = (t == 4) ? 1 : ((t == 5) ? 2 : 0);
            foreach (rows[i]) begin
                if (rows[i].test == t) begin
                    send_row(rows[i], (t == 5) ? 20 : 1000, ok);
                    if (ok) sent++;
                    else if (t != 5) begin
                        $display("error at %0t ns: row %0d never accepted", $time, i);
                        tb_errors++;
                    end
                end
            end
            if (t == 5 && sent != NUM_UNITS + QUEUE_DEPTH) begin
                $display("Fail at %0t ns: %0d accepted before in_ready fell, expected %0d",
                         $time, sent, NUM_UNITS + QUEUE_DEPTH);
                tb_errors++;
            end
            if (t == 5) ready_mode = 0;   // release the bus
            while (pending_count != 0) begin
                @(posedge clock);
                #1;
            end
            repeat (3) @(posedge clock);
            #1;
            if (complete_count - cmp_before != accept_count - acc_before) begin
                $display("Fail at %0t ns: %0d completions for %0d accepted operations", $time,
                         complete_count - cmp_before, accept_count - acc_before);
                tb_errors++;
            end
            if (error_count + tb_errors != errs_before) tests_failed++;
            $display("test %0d: %0d operations, %s", t, sent,
                     (error_count + tb_errors == errs_before) ? "passed" : "failed");
        end
        $display("tests 6, failed %0d, accepted %0d, completed %0d, errors %0d",
                 tests_failed, accept_count, complete_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock_gen.sv
// clock and reset generator for the testbench
module tb_clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;   // 10 ns period
    end

    // reset held for two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule
